// File: Makefile
# Verilator build and run for the memory subsystem testbench

TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_mem_subsystem
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: rtl/cpu_pkg.sv
// Pipeline types for the memory-access stage of the 16-bit processor
`default_nettype none

package cpu_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int data_w     = 16; // Machine word
    localparam int reg_addr_w = 4;  // Register file index

    ////////////////////
    // Execute to memory access
    ////////////////////

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  mem_write;
        logic                  mem_read;
        logic                  mem_to_reg;  // Load result goes to the register file
        logic                  call;
        logic                  ret_future;  // Return seen ahead of write-back
        logic                  halt;
        logic [reg_addr_w-1:0] reg_rd;      // Destination register
        logic [data_w-1:0]     alu_result;  // ALU result or stack pointer
        logic [data_w-1:0]     store_data;  // Store data, PC during a call
    } ex_mem_t;

    ////////////////////
    // Memory access to write-back
    ////////////////////

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  ret_future;
        logic                  halt;
        logic [reg_addr_w-1:0] reg_rd;      // Zero when not writing
        logic [data_w-1:0]     alu_result;  // Adjusted stack pointer on call and return
        logic [data_w-1:0]     read_data;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rtl/data_memory.sv
// Word-addressed data memory with one synchronous read and write port
`timescale 1ns/1ps
`default_nettype none

module data_memory
    import cpu_pkg::*;
#(
    parameter int depth_log2 = 8
) (
    input  wire logic              clk,
    input  wire logic [data_w-1:0] addr,
    input  wire logic              re,
    input  wire logic              we,
    input  wire logic [data_w-1:0] wdata,
    output logic      [data_w-1:0] rdata
);

    localparam int depth = 1 << depth_log2;

    ////////////////////
    // Storage
    ////////////////////

    logic [data_w-1:0]     mem [0:depth-1];
    logic [depth_log2-1:0] idx;

    // Upper address bits wrap
    assign idx = addr[depth_log2-1:0];

    ////////////////////
    // Access port
    ////////////////////

    // Write and read share the edge, so a read
    // of the written word sees the old contents
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
        if (re) begin
            rdata <= mem[idx]; // Holds when re is low
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
// Line request and response types for the unified main memory
`default_nettype none

package mem_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int line_w      = 32; // One memory line
    localparam int line_addr_w = 15; // Line index from the cache side

    ////////////////////
    // Request from the cache side
    ////////////////////

    typedef struct packed {
        logic                   valid;
        logic                   rw;    // 1 write, 0 read
        logic [line_addr_w-1:0] addr;
        logic [line_w-1:0]      data;  // Write data, ignored on reads
    } mem_req_t;

    ////////////////////
    // Response back to the cache side
    ////////////////////

    typedef struct packed {
        logic              ready; // Single-cycle completion pulse
        logic [line_w-1:0] data;  // Line read, valid with ready
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/mem_stage.sv
// Memory-access stage with stack adjustment, data memory and MEM/WB register
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import cpu_pkg::*;
#(
    parameter int dmem_depth_log2 = 8
) (
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire ex_mem_t ex,
    output mem_wb_t      wb
);

    logic [data_w-1:0]     dmem_addr;
    logic [data_w-1:0]     dmem_wdata;
    logic [data_w-1:0]     dmem_rdata;
    logic                  dmem_re;
    logic                  dmem_we;
    logic [data_w-1:0]     fwd_result;  // Result handed to write-back

    logic                  valid_q;
    logic                  reg_write_q;
    logic                  mem_to_reg_q;
    logic                  ret_future_q;
    logic                  halt_q;
    logic [reg_addr_w-1:0] reg_rd_q;
    logic [data_w-1:0]     alu_result_q;

    ////////////////////
    // Stack pointer rules
    ////////////////////

    always_comb begin
        dmem_addr  = ex.alu_result;
        dmem_wdata = ex.store_data;
        fwd_result = ex.alu_result;
        if (ex.call) begin
            // Push return address, SP moves down
            dmem_wdata = ex.store_data + data_w'(1);
            fwd_result = ex.alu_result - data_w'(1);
        end else if (ex.ret_future) begin
            // SP moves up, pop from the new top
            dmem_addr  = ex.alu_result + data_w'(1);
            fwd_result = ex.alu_result + data_w'(1);
        end
    end

    assign dmem_re = ex.valid && ex.mem_read;
    assign dmem_we = ex.valid && ex.mem_write;

    data_memory #(
        .depth_log2 (dmem_depth_log2)
    ) u_data_memory (
        .clk   (clk),
        .addr  (dmem_addr),
        .re    (dmem_re),
        .we    (dmem_we),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    ////////////////////
    // MEM/WB register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q      <= 1'b0;
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
            ret_future_q <= 1'b0;
            halt_q       <= 1'b0;
            reg_rd_q     <= '0;
        end else begin
            valid_q      <= ex.valid;
            reg_write_q  <= ex.valid && ex.reg_write;
            mem_to_reg_q <= ex.valid && ex.mem_to_reg;
            ret_future_q <= ex.valid && ex.ret_future;
            halt_q       <= ex.valid && ex.halt;
            // Destination zeroed when nothing is written
            reg_rd_q     <= (ex.valid && ex.reg_write) ? ex.reg_rd : '0;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_q <= fwd_result;
    end

    assign wb.valid      = valid_q;
    assign wb.reg_write  = reg_write_q;
    assign wb.mem_to_reg = mem_to_reg_q;
    assign wb.ret_future = ret_future_q;
    assign wb.halt       = halt_q;
    assign wb.reg_rd     = reg_rd_q;
    assign wb.alu_result = alu_result_q;
    assign wb.read_data  = dmem_rdata; // Already registered in the memory

endmodule

`default_nettype wire

// File: rtl/mem_subsystem_top.sv
// Memory subsystem top joining the memory-access stage and unified memory
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import cpu_pkg::*;
    import mem_pkg::*;
#(
    parameter int dmem_depth_log2 = 8,
    parameter int umem_depth_log2 = 10,
    parameter int umem_latency    = 4   // At least 1
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire ex_mem_t  ex,
    output mem_wb_t       wb,
    input  wire mem_req_t req,
    output mem_rsp_t      rsp
);

    ////////////////////
    // Pipeline path
    ////////////////////

    mem_stage #(
        .dmem_depth_log2 (dmem_depth_log2)
    ) u_mem_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (ex),
        .wb     (wb)
    );

    ////////////////////
    // Line path from the cache side
    ////////////////////

    unified_memory #(
        .depth_log2 (umem_depth_log2),
        .latency    (umem_latency)
    ) u_unified_memory (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp)
    );

endmodule

`default_nettype wire

// File: rtl/unified_memory.sv
// Unified line memory serving one request at a time with a fixed latency
`timescale 1ns/1ps
`default_nettype none

module unified_memory
    import mem_pkg::*;
#(
    parameter int depth_log2 = 10,
    parameter int latency    = 4
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire mem_req_t req,
    output mem_rsp_t      rsp
);

    localparam int depth = 1 << depth_log2;
    localparam int cnt_w = (latency > 1) ? $clog2(latency) : 1;

    ////////////////////
    // State
    ////////////////////

    logic [line_w-1:0]     mem [0:depth-1];
    logic                  busy;
    logic [cnt_w-1:0]      cnt;     // Edges left before ready
    logic [depth_log2-1:0] addr_q;  // Line of the request in service
    logic                  ready_q;
    logic [line_w-1:0]     rdata_q;

    logic                  accept;
    logic                  done;
    logic [depth_log2-1:0] req_idx;

    assign accept  = req.valid && !busy;
    assign done    = busy && (cnt == '0);
    assign req_idx = req.addr[depth_log2-1:0]; // Wraps modulo depth

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= cnt_w'(latency - 1);
            end else if (done) begin
                busy    <= 1'b0;
                ready_q <= 1'b1; // One cycle only
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    ////////////////////
    // Array and data path
    ////////////////////

    // Writes land at acceptance and complete with ready
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_idx;
            if (req.rw) begin
                mem[req_idx] <= req.data;
            end
        end
        if (done) begin
            rdata_q <= mem[addr_q];
        end
    end

    assign rsp.ready = ready_q;
    assign rsp.data  = rdata_q;

endmodule

`default_nettype wire

// File: verif/mem_checker.sv
// Testbench checker predicting stage results and line responses from the memory rules
`timescale 1ns/1ps
`default_nettype none

module mem_checker
    import cpu_pkg::*;
    import mem_pkg::*;
#(
    parameter int dmem_depth_log2 = 8,
    parameter int umem_depth_log2 = 10,
    parameter int umem_latency    = 4
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire ex_mem_t  ex,
    input  wire mem_wb_t  wb,
    input  wire mem_req_t req,
    input  wire mem_rsp_t rsp,
    input  var  int       entry_id,  // Table entry on ex, -1 for a bubble
    output int            errors,
    output int            tests
);

    localparam int dmem_depth = 1 << dmem_depth_log2;
    localparam int umem_depth = 1 << umem_depth_log2;

    ////////////////////
    // Models and predictions
    ////////////////////

    logic [data_w-1:0]          dmem [0:dmem_depth-1];
    logic [line_w-1:0]          umem [0:umem_depth-1];

    mem_wb_t                    exp_wb    = '0;
    logic                       exp_rd    = 1'b0;  // read_data is meaningful
    logic                       exp_ready = 1'b0;
    logic [line_w-1:0]          exp_line  = '0;
    int                         exp_id    = -1;
    logic                       in_reset  = 1'b1;
    int                         age       = -1;    // Edges since acceptance, -1 when idle
    logic                       cur_rw    = 1'b0;
    logic [umem_depth_log2-1:0] cur_idx   = '0;
    int                         line_no   = 0;
    int                         err_cnt   = 0;
    int                         test_cnt  = 0;
    int                         rst_err   = 0;
    logic                       rst_done  = 1'b0;

    assign errors = err_cnt;
    assign tests  = test_cnt;

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want, inout int n);
        if (got !== want) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
            n++;
        end
    endtask

    task automatic report_test(input string what, input int n);
        if (n == 0) begin
            $display("%s: pass", what);
        end else begin
            $display("%s: failed with %0d mismatches", what, n);
        end
    endtask

    // Inputs are stable here, driven on the falling edge
    always @(posedge clk) begin
        logic [data_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] fwd;
        logic              wr;
        in_reset  = !arst_n;
        exp_ready = 1'b0;
        if (in_reset) begin
            exp_wb = '0;
            exp_rd = 1'b0;
            exp_id = -1;
            age    = -1;
        end else begin
            addr  = ex.alu_result;
            wdata = ex.store_data;
            fwd   = ex.alu_result;
            if (ex.call) begin
                wdata = ex.store_data + 16'd1;  // Return address
                fwd   = ex.alu_result - 16'd1;
            end else if (ex.ret_future) begin
                addr = ex.alu_result + 16'd1;
                fwd  = addr;
            end
            wr = ex.valid && ex.reg_write;
            exp_wb.valid      = ex.valid;
            exp_wb.reg_write  = wr;
            exp_wb.mem_to_reg = ex.valid && ex.mem_to_reg;
            exp_wb.ret_future = ex.valid && ex.ret_future;
            exp_wb.halt       = ex.valid && ex.halt;
            exp_wb.reg_rd     = wr ? ex.reg_rd : '0;
            exp_wb.alu_result = fwd;
            exp_rd = ex.valid && ex.mem_read;
            exp_id = entry_id;
            // Read sees the word from before this edge's write
            if (exp_rd) begin
                exp_wb.read_data = dmem[addr[dmem_depth_log2-1:0]];
            end
            if (ex.valid && ex.mem_write) begin
                dmem[addr[dmem_depth_log2-1:0]] = wdata;
            end

            ////////////////////
            // Line port
            ////////////////////
            if (age >= 0) begin
                age++;
                if (age == umem_latency) begin
                    exp_ready = 1'b1;
                    exp_line  = umem[cur_idx];
                    age       = -1;  // Idle again
                end
            end else if (req.valid) begin
                age     = 0;
                cur_rw  = req.rw;
                cur_idx = req.addr[umem_depth_log2-1:0];
                line_no++;
                if (req.rw) begin
                    umem[cur_idx] = req.data;  // Write lands at acceptance
                end
            end
        end
    end

    // Outputs settled since the rising edge
    always @(negedge clk) begin
        int n;
        int m;
        n = 0;
        m = 0;
        compare("wb.valid", 32'(wb.valid), 32'(exp_wb.valid), n);
        compare("wb.reg_write", 32'(wb.reg_write), 32'(exp_wb.reg_write), n);
        compare("wb.mem_to_reg", 32'(wb.mem_to_reg), 32'(exp_wb.mem_to_reg), n);
        compare("wb.ret_future", 32'(wb.ret_future), 32'(exp_wb.ret_future), n);
        compare("wb.halt", 32'(wb.halt), 32'(exp_wb.halt), n);
        compare("wb.reg_rd", 32'(wb.reg_rd), 32'(exp_wb.reg_rd), n);
        if (exp_wb.valid) begin
            compare("wb.alu_result", 32'(wb.alu_result), 32'(exp_wb.alu_result), n);
        end
        if (exp_rd) begin
            compare("wb.read_data", 32'(wb.read_data), 32'(exp_wb.read_data), n);
        end
        compare("rsp.ready", 32'(rsp.ready), 32'(exp_ready), m);
        if (exp_ready && !cur_rw) begin
            compare("rsp.data", rsp.data, exp_line, m);
        end
        err_cnt = err_cnt + n + m;
        if (in_reset) begin
            rst_err = rst_err + n + m;
        end else begin
            if (!rst_done) begin
                report_test("reset state", rst_err);
                rst_done = 1'b1;
                test_cnt++;
            end
            if (exp_id >= 0) begin
                report_test($sformatf("entry %0d", exp_id), n);
                test_cnt++;
            end
            if (exp_ready) begin
                report_test($sformatf("line request %0d (%s line 0x%h)", line_no,
                                      cur_rw ? "write" : "read", cur_idx), m);
                test_cnt++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_mem_subsystem.sv
// Testbench for the memory subsystem, applying a stimulus table to the stage and line port
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
    import cpu_pkg::*;
    import mem_pkg::*;
();

    localparam int dmem_depth_log2 = 8;
    localparam int umem_depth_log2 = 10;
    localparam int umem_latency    = 4;
    localparam int req_timeout     = 4 * umem_latency + 8;  // Cycles a request may wait
    localparam int drain_limit     = 64;

    // Control bits: valid reg_write mem_write mem_read mem_to_reg call ret_future halt
    localparam logic [7:0] c_store = 8'b1010_0000;
    localparam logic [7:0] c_load  = 8'b1101_1000;
    localparam logic [7:0] c_rmw   = 8'b1111_1000;  // Read and write on one edge
    localparam logic [7:0] c_alu   = 8'b1100_0000;
    localparam logic [7:0] c_nowr  = 8'b1000_1000;
    localparam logic [7:0] c_call  = 8'b1110_0100;
    localparam logic [7:0] c_ret   = 8'b1101_0010;
    localparam logic [7:0] c_halt  = 8'b1000_0001;
    localparam logic [7:0] c_junk  = 8'b0111_1111;  // Not valid
    localparam logic [7:0] c_nop   = 8'b0000_0000;

    typedef struct packed {
        ex_mem_t                ex;
        logic                   rnd;    // Store data from the LFSR
        logic [1:0]             lreq;   // Bit 1 request, bit 0 write
        logic [line_addr_w-1:0] laddr;
    } entry_t;

    logic        clk    = 1'b0;
    logic        arst_n = 1'b0;
    ex_mem_t     ex;
    mem_wb_t     wb;
    mem_req_t    req;
    mem_rsp_t    rsp;
    int          entry_id;
    int          errors;
    int          tests;
    logic [31:0] lfsr;
    int          wait_cnt;
    logic        timed_out;
    entry_t      stim_q[$];
    mem_req_t    line_q[$];  // Line requests not yet on the port

    always #2 clk = ~clk;

    mem_subsystem_top #(
        .dmem_depth_log2 (dmem_depth_log2),
        .umem_depth_log2 (umem_depth_log2),
        .umem_latency    (umem_latency)
    ) u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (ex),
        .wb     (wb),
        .req    (req),
        .rsp    (rsp)
    );

    mem_checker #(
        .dmem_depth_log2 (dmem_depth_log2),
        .umem_depth_log2 (umem_depth_log2),
        .umem_latency    (umem_latency)
    ) u_checker (
        .clk      (clk),
        .arst_n   (arst_n),
        .ex       (ex),
        .wb       (wb),
        .req      (req),
        .rsp      (rsp),
        .entry_id (entry_id),
        .errors   (errors),
        .tests    (tests)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        b;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            bits = {bits[30:0], b};
        end
        return bits;
    endfunction

    task automatic add_entry(input logic [7:0] ctrl, input logic [3:0] rd,
                             input logic [15:0] alu, input logic [15:0] sd, input logic rnd,
                             input logic [1:0] lreq, input logic [14:0] laddr);
        entry_t t;
        t.ex    = {ctrl, rd, alu, sd};
        t.rnd   = rnd;
        t.lreq  = lreq;
        t.laddr = laddr;
        stim_q.push_back(t);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        add_entry(c_store, 4'h0, 16'h0010, 16'h0000, 1'b1, 2'b00, 15'h0000);
        add_entry(c_store, 4'h0, 16'h0011, 16'h0000, 1'b1, 2'b00, 15'h0000);
        add_entry(c_load,  4'h1, 16'h0010, 16'h0000, 1'b0, 2'b00, 15'h0000);
        add_entry(c_load,  4'h2, 16'h0011, 16'h0000, 1'b0, 2'b00, 15'h0000);
        add_entry(c_store, 4'h0, 16'h0020, 16'h0000, 1'b1, 2'b00, 15'h0000);
        add_entry(c_rmw,   4'h3, 16'h0020, 16'h0000, 1'b1, 2'b00, 15'h0000);  // Old word back
        add_entry(c_load,  4'h4, 16'h0020, 16'h0000, 1'b0, 2'b00, 15'h0000);
        add_entry(c_load,  4'h5, 16'h0110, 16'h0000, 1'b0, 2'b00, 15'h0000);  // Wraps to 0x10
        // Line requests pile up behind the busy memory
        add_entry(c_alu,   4'h6, 16'h1234, 16'h0000, 1'b0, 2'b11, 15'h0005);
        add_entry(c_alu,   4'h7, 16'hbeef, 16'h0000, 1'b0, 2'b11, 15'h0123);
        add_entry(c_nowr,  4'h8, 16'h5555, 16'h0000, 1'b0, 2'b10, 15'h0005);
        add_entry(c_halt,  4'h9, 16'h0000, 16'h0000, 1'b0, 2'b10, 15'h0123);
        add_entry(c_call,  4'hf, 16'h0080, 16'h0123, 1'b0, 2'b11, 15'h7405);  // Line 0x005 again
        add_entry(c_ret,   4'hf, 16'h007f, 16'h0000, 1'b0, 2'b10, 15'h0005);
        // Nested calls unwound in order
        add_entry(c_call,  4'hf, 16'h007f, 16'h0200, 1'b0, 2'b00, 15'h0000);
        add_entry(c_call,  4'hf, 16'h007e, 16'h0000, 1'b1, 2'b00, 15'h0000);
        add_entry(c_ret,   4'hf, 16'h007d, 16'h0000, 1'b0, 2'b00, 15'h0000);
        add_entry(c_ret,   4'hf, 16'h007e, 16'h0000, 1'b0, 2'b00, 15'h0000);
        add_entry(c_junk,  4'ha, 16'h0010, 16'hdead, 1'b0, 2'b00, 15'h0000);  // Must not store
        add_entry(c_nop,   4'hb, 16'h0011, 16'h0000, 1'b0, 2'b10, 15'h0123);
        add_entry(c_load,  4'hc, 16'h0010, 16'h0000, 1'b0, 2'b00, 15'h0000);
    endtask

    // One falling edge: retire a finished line request, present the next, drive ex
    task automatic step_cycle(input ex_mem_t e, input int id);
        @(negedge clk);
        if (req.valid && rsp.ready) begin
            req.valid = 1'b0;
        end
        if (!req.valid && line_q.size() > 0) begin
            req      = line_q.pop_front();
            wait_cnt = 0;
        end
        if (req.valid) begin
            wait_cnt++;
            if (wait_cnt > req_timeout) begin
                $display("Timeout: no ready for the line request at 0x%h", req.addr);
                timed_out = 1'b1;
            end
        end
        ex       = e;
        entry_id = id;
    endtask

    task automatic apply_entry(input int idx);
        entry_t      t;
        mem_req_t    r;
        logic [31:0] bits;
        t = stim_q[idx];
        if (t.rnd) begin
            bits            = take_bits(data_w);
            t.ex.store_data = bits[data_w-1:0];
        end
        if (t.lreq[1]) begin
            r.valid = 1'b1;
            r.rw    = t.lreq[0];
            r.addr  = t.laddr;
            r.data  = t.lreq[0] ? take_bits(line_w) : '0;
            line_q.push_back(r);
        end
        step_cycle(t.ex, idx);
    endtask

    initial begin
        int k;
        ex        = '0;
        req       = '0;
        entry_id  = -1;
        wait_cnt  = 0;
        timed_out = 1'b0;
        lfsr      = 32'h0d47_6e44;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (stim_q[i]) begin
            if (!timed_out) begin
                apply_entry(i);
            end
        end
        // Bubbles until the line port is empty and the last entry is checked
        k = 0;
        while (!timed_out && (req.valid || line_q.size() > 0 || k < 2)) begin
            step_cycle('0, -1);
            k++;
            if (k > drain_limit) begin
                $display("Timeout: the line port did not drain");
                timed_out = 1'b1;
            end
        end
        // Checker finishes the last falling-edge compare first
        @(posedge clk);
        $display("Tests: %0d, errors: %0d", tests, errors);
        if (timed_out || errors != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/cpu_pkg.sv
rtl/mem_pkg.sv
rtl/data_memory.sv
rtl/unified_memory.sv
rtl/mem_stage.sv
rtl/mem_subsystem_top.sv
verif/mem_checker.sv
verif/tb_mem_subsystem.sv
